// File: verilog/periph_map_pkg.sv
/* slot bus map. The slot field is addr[23:20], so each slot spans 1 MiB.
   Channel k is at slot SLOT_CHAN_BASE+k, so at most 6 channels fit below slot 15 */
package periph_map_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  ////////////////////////////////////////////////////////////
  // slot field and slot numbers
  ////////////////////////////////////////////////////////////
  localparam int SLOT_MSB  = 23;
  localparam int SLOT_LSB  = 20;
  localparam int NUM_SLOTS = 16;           // one per value of the slot field

  localparam int SLOT_LED       = 7;       // write sets LEDs, read gives DIP
  localparam int SLOT_CHAN_BASE = 9;       // channel 0, others follow

  // within a channel slot, addr bit 2 picks data view over status view
  localparam int VIEW_BIT = 2;

  ////////////////////////////////////////////////////////////
  // board io widths
  ////////////////////////////////////////////////////////////
  localparam int LED_W = 8;
  localparam int DIP_W = 16;

endpackage

// File: verilog/chan_fifo_pkg.sv
/* receive channel constants and the 32-bit channel read word.
   The count field is 12 bits, so a channel holds at most 2048 bytes */
package chan_fifo_pkg;

  localparam int BYTE_W        = 8;        // channel payload
  localparam int CNT_W         = 12;       // count field of status word
  localparam int ALMOST_MARGIN = 2;        // almost-full at depth minus this

  ////////////////////////////////////////////////////////////
  // channel read word, one 32-bit word seen two ways
  ////////////////////////////////////////////////////////////

  // status view, addr bit 2 clear
  typedef struct packed {
    logic             empty;               // bit 31
    logic             almost_full;         // bit 30
    logic             full;                // bit 29
    logic             rd_err;              // bit 28, sticky
    logic             wr_err;              // bit 27, sticky
    logic [14:0]      rsvd;                // reads zero
    logic [CNT_W-1:0] count;               // bits 11:0
  } chan_stat_t;

  // data view, addr bit 2 set
  typedef struct packed {
    logic              empty;              // bit 31
    logic [22:0]       rsvd;               // reads zero
    logic [BYTE_W-1:0] head;               // byte at the head of the queue
  } chan_data_t;

  typedef union packed {
    chan_stat_t stat;
    chan_data_t data;
  } chan_word_u;

endpackage

// File: verilog/slot_decoder.sv
/* strobes are combinational off req_i and the address; only the LED register is clocked.
   Slot select is formed even without req_i, so qualify it before use */
`timescale 1ns/10ps

module slot_decoder
#(
  parameter int NUM_CHAN = 4
)
(
  input  logic                                msoc_clk,
  input  logic                                rstn,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [periph_map_pkg::ADDR_W-1:0]   addr_i,
  input  logic [periph_map_pkg::DATA_W-1:0]   wdata_i,
  output logic [periph_map_pkg::NUM_SLOTS-1:0] slot_sel_o,
  output logic [NUM_CHAN-1:0]                 pop_o,
  output logic [NUM_CHAN-1:0]                 stat_rd_o,
  output logic [periph_map_pkg::LED_W-1:0]    led_o
);
  import periph_map_pkg::*;

  logic [SLOT_MSB-SLOT_LSB:0] slot_f;
  logic [NUM_SLOTS-1:0]       slot_sel;
  logic                       wr_cyc;
  logic                       rd_cyc;

  assign slot_f   = addr_i[SLOT_MSB:SLOT_LSB];
  assign slot_sel = NUM_SLOTS'(1) << slot_f;   // one-hot
  assign wr_cyc   = req_i & we_i;
  assign rd_cyc   = req_i & ~we_i;

  assign slot_sel_o = slot_sel;

  // per channel strobes
  always_comb
  begin
    for (int k = 0; k < NUM_CHAN; k++)
    begin
      pop_o[k]     = wr_cyc & slot_sel[SLOT_CHAN_BASE + k];   // write pops, data ignored
      stat_rd_o[k] = rd_cyc & slot_sel[SLOT_CHAN_BASE + k] & ~addr_i[VIEW_BIT];
    end
  end

  ////////////////////////////////////////////////////////////
  // LED register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_o <= '0;
    end
    else if (wr_cyc && slot_sel[SLOT_LED])
    begin
      led_o <= wdata_i[LED_W-1:0];         // low byte only
    end
  end

endmodule

// File: verilog/rx_chan_fifo.sv
/* single clock byte FIFO, DEPTH a power of two from 4 to 2048.
   Error flags are sticky until a status-view read; a pop makes room for a push to a full queue */
`timescale 1ns/10ps

module rx_chan_fifo
#(
  parameter int DEPTH = 8
)
(
  input  logic                              msoc_clk,
  input  logic                              rstn,
  input  logic                              push_i,
  input  logic [chan_fifo_pkg::BYTE_W-1:0]  push_data_i,
  input  logic                              pop_i,
  input  logic                              stat_rd_i,
  input  logic                              view_data_i,
  output chan_fifo_pkg::chan_word_u         word_o
);
  import chan_fifo_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [BYTE_W-1:0] mem [DEPTH];          // circular byte store
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              empty;
  logic              full;
  logic              almost_full;
  logic              do_push;
  logic              do_pop;
  logic              rd_err;
  logic              wr_err;

  assign empty       = (count == '0);
  assign full        = (count == CNT_W'(DEPTH));
  assign almost_full = (count >= CNT_W'(DEPTH - ALMOST_MARGIN));

  assign do_pop  = pop_i & ~empty;
  assign do_push = push_i & (~full | pop_i);   // full implies not empty

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers, count and sticky error flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rd_err <= 1'b0;
      wr_err <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;           // wraps at DEPTH
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // both or neither
      endcase
      // a new error at the clearing edge still lands
      wr_err <= (wr_err & ~stat_rd_i) | (push_i & ~do_push);
      rd_err <= (rd_err & ~stat_rd_i) | (pop_i & empty);
    end
  end

  // read word, shows state before the edge
  always_comb
  begin
    word_o = '0;
    if (view_data_i)
    begin
      word_o.data.empty = empty;
      word_o.data.head  = mem[rd_ptr];
    end
    else
    begin
      word_o.stat.empty       = empty;
      word_o.stat.almost_full = almost_full;
      word_o.stat.full        = full;
      word_o.stat.rd_err      = rd_err;
      word_o.stat.wr_err      = wr_err;
      word_o.stat.count       = count;
    end
  end

endmodule

// File: verilog/read_combiner.sv
/* one cycle from read strobe to rdata_o, no back-pressure.
   DIP reads return dip_i as it stood two edges before the data appears */
`timescale 1ns/10ps

module read_combiner
#(
  parameter int NUM_CHAN = 4
)
(
  input  logic                                       msoc_clk,
  input  logic                                       rstn,
  input  logic                                       req_i,
  input  logic                                       we_i,
  input  logic [periph_map_pkg::NUM_SLOTS-1:0]       slot_sel_i,
  input  logic [NUM_CHAN*periph_map_pkg::DATA_W-1:0] chan_word_i,
  input  logic [periph_map_pkg::DIP_W-1:0]           dip_i,
  output logic [periph_map_pkg::DATA_W-1:0]          rdata_o,
  output logic                                       rvalid_o
);
  import periph_map_pkg::*;
  import chan_fifo_pkg::*;

  chan_word_u        chan_word [NUM_CHAN];
  logic [DIP_W-1:0]  dip_q;                // sampled switches
  logic [DATA_W-1:0] rd_mux;
  logic              rd_cyc;

  assign rd_cyc = req_i & ~we_i;

  ////////////////////////////////////////////////////////////
  // OR mux over the one-hot slot select
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    rd_mux = '0;                           // unmapped slots read zero
    if (slot_sel_i[SLOT_LED])
      rd_mux |= DATA_W'(dip_q);
    for (int k = 0; k < NUM_CHAN; k++)
    begin
      chan_word[k] = chan_word_i[k*DATA_W +: DATA_W];
      if (slot_sel_i[SLOT_CHAN_BASE + k])
        rd_mux |= chan_word[k];
    end
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      dip_q    <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      dip_q    <= dip_i;                   // every cycle
      rvalid_o <= rd_cyc;                  // single cycle pulse per read
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (rd_cyc)
      rdata_o <= rd_mux;
  end

endmodule

// File: verilog/periph_soc_top.sv
/* peripheral side of the SoC: slot decoder, NUM_CHAN receive channels, read combiner.
   NUM_CHAN is 1 to 6; DEPTH is a power of two from 4 to 2048 */
`timescale 1ns/10ps

module periph_soc_top
#(
  parameter int NUM_CHAN = 4,
  parameter int DEPTH    = 8
)
(
  input  logic                                        msoc_clk,
  input  logic                                        rstn,
  // bus master side
  input  logic                                        req_i,
  input  logic                                        we_i,
  input  logic [periph_map_pkg::ADDR_W-1:0]           addr_i,
  input  logic [periph_map_pkg::DATA_W-1:0]           wdata_i,
  // byte producers, one strobe and byte per channel
  input  logic [NUM_CHAN-1:0]                         push_i,
  input  logic [NUM_CHAN*chan_fifo_pkg::BYTE_W-1:0]   push_data_i,
  // board io
  input  logic [periph_map_pkg::DIP_W-1:0]            dip_i,
  output logic [periph_map_pkg::DATA_W-1:0]           rdata_o,
  output logic                                        rvalid_o,
  output logic [periph_map_pkg::LED_W-1:0]            led_o
);
  import periph_map_pkg::*;
  import chan_fifo_pkg::*;

  logic [NUM_SLOTS-1:0]       slot_sel;    // one-hot slot of the current request
  logic [NUM_CHAN-1:0]        pop;
  logic [NUM_CHAN-1:0]        stat_rd;
  logic [NUM_CHAN*DATA_W-1:0] chan_word;   // read words of all channels

  slot_decoder #(.NUM_CHAN(NUM_CHAN)) u_dec (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .slot_sel_o (slot_sel),
    .pop_o      (pop),
    .stat_rd_o  (stat_rd),
    .led_o      (led_o)
  );

  ////////////////////////////////////////////////////////////
  // receive channel bank
  ////////////////////////////////////////////////////////////
  genvar k;
  generate
    for (k = 0; k < NUM_CHAN; k++)
    begin : g_chan
      rx_chan_fifo #(.DEPTH(DEPTH)) u_chan (
        .msoc_clk    (msoc_clk),
        .rstn        (rstn),
        .push_i      (push_i[k]),
        .push_data_i (push_data_i[k*BYTE_W +: BYTE_W]),
        .pop_i       (pop[k]),
        .stat_rd_i   (stat_rd[k]),
        .view_data_i (addr_i[VIEW_BIT]),
        .word_o      (chan_word[k*DATA_W +: DATA_W])
      );
    end
  endgenerate

  read_combiner #(.NUM_CHAN(NUM_CHAN)) u_rd (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .req_i       (req_i),
    .we_i        (we_i),
    .slot_sel_i  (slot_sel),
    .chan_word_i (chan_word),
    .dip_i       (dip_i),
    .rdata_o     (rdata_o),
    .rvalid_o    (rvalid_o)
  );

endmodule

// File: bench/periph_soc_chk.sv
/* bus timing checks, bound into every periph_soc_top instance.
   Checks are off while rstn is low */
`timescale 1ns/10ps

module periph_soc_chk
(
  input logic                              msoc_clk,
  input logic                              rstn,
  input logic                              req_i,
  input logic                              we_i,
  input logic [periph_map_pkg::ADDR_W-1:0] addr_i,
  input logic                              rvalid_o,
  input logic [periph_map_pkg::LED_W-1:0]  led_o
);
  import periph_map_pkg::*;

  logic rd_cyc;
  logic wr_cyc;
  logic led_wr;

  assign rd_cyc = req_i & ~we_i;
  assign wr_cyc = req_i & we_i;
  assign led_wr = wr_cyc & (addr_i[SLOT_MSB:SLOT_LSB] == 4'(SLOT_LED));

  a_rvalid_after_read: assert property (@(posedge msoc_clk) disable iff (!rstn)
    rd_cyc |=> rvalid_o)
    else $error("rvalid_o missing one cycle after a read");

  a_no_rvalid_after_write: assert property (@(posedge msoc_clk) disable iff (!rstn)
    wr_cyc |=> !rvalid_o)
    else $error("rvalid_o raised after a write");

  a_rvalid_only_after_read: assert property (@(posedge msoc_clk) disable iff (!rstn)
    rvalid_o |-> $past(rd_cyc))
    else $error("rvalid_o raised without a read the cycle before");

  a_led_only_on_write: assert property (@(posedge msoc_clk) disable iff (!rstn)
    (led_o != $past(led_o)) |-> $past(led_wr))
    else $error("led_o changed without a write to the LED slot");

endmodule

bind periph_soc_top periph_soc_chk u_chk (
  .msoc_clk (msoc_clk),
  .rstn     (rstn),
  .req_i    (req_i),
  .we_i     (we_i),
  .addr_i   (addr_i),
  .rvalid_o (rvalid_o),
  .led_o    (led_o)
);

// File: bench/tb_periph_soc.sv
/* directed tests of periph_soc_top with NUM_CHAN 4 and DEPTH 8.
   Byte values come from a fixed-seed LFSR, so every run drives the same bytes */
`timescale 1ns/10ps

module tb_periph_soc;
  import periph_map_pkg::*;
  import chan_fifo_pkg::*;

  localparam int NUM_CHAN    = 4;
  localparam int DEPTH       = 8;
  localparam int NUM_OPS     = 40 + 3 * DEPTH;          // bus ops and pushes of all tests
  localparam int TIMEOUT_CYC = 8 + 4 * NUM_OPS + 100;   // reset plus four cycles per op plus margin

  logic                       msoc_clk;
  logic                       rstn;
  logic                       req_i;
  logic                       we_i;
  logic [ADDR_W-1:0]          addr_i;
  logic [DATA_W-1:0]          wdata_i;
  logic [NUM_CHAN-1:0]        push_i;
  logic [NUM_CHAN*BYTE_W-1:0] push_data_i;
  logic [DIP_W-1:0]           dip_i;
  logic [DATA_W-1:0]          rdata_o;
  logic                       rvalid_o;
  logic [LED_W-1:0]           led_o;
  logic [31:0]                lfsr;
  int                         errors;
  int                         checks;
  int                         cyc_cnt;

  periph_soc_top #(.NUM_CHAN(NUM_CHAN), .DEPTH(DEPTH)) u_dut (.*);

  initial
  begin
    msoc_clk = 1'b0;
    forever #2 msoc_clk = ~msoc_clk;      // 4 ns period
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      b    = {b[6:0], lfsr[0]};           // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // expected status word built from the channel map rules
  function automatic logic [31:0] stat_exp(input int cnt, input logic rerr, input logic werr);
    return {cnt == 0, cnt >= DEPTH - 2, cnt == DEPTH, rerr, werr, 15'b0, 12'(cnt)};
  endfunction

  function automatic logic [31:0] slot_addr(input int slot, input logic view_data);
    logic [31:0] a;
    a           = 32'(slot) << SLOT_LSB;
    a[VIEW_BIT] = view_data;
    return a;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and producer drivers
  ////////////////////////////////////////////////////////////
  task bus_write(input int slot, input logic [31:0] data);
    @(posedge msoc_clk);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= slot_addr(slot, 1'b0);
    wdata_i <= data;
    @(posedge msoc_clk);                  // DUT takes the write here
    req_i   <= 1'b0;
    we_i    <= 1'b0;
  endtask

  task bus_read(input int slot, input logic view_data, output logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge msoc_clk);
    req_i  <= 1'b1;
    we_i   <= 1'b0;
    addr_i <= slot_addr(slot, view_data);
    @(posedge msoc_clk);
    req_i  <= 1'b0;
    @(negedge msoc_clk);
    while (!rvalid_o && waited < 4)
    begin
      @(negedge msoc_clk);
      waited++;
    end
    data = rdata_o;
    assert (rvalid_o)
    else
    begin
      errors++;
      $display("read of slot %0d got no valid response", slot);
    end
  endtask

  task push_byte(input int ch, input logic [7:0] b);
    @(posedge msoc_clk);
    push_i[ch]                       <= 1'b1;
    push_data_i[ch*BYTE_W +: BYTE_W] <= b;
    @(posedge msoc_clk);
    push_i[ch]                       <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task reset_state();
    logic [31:0] d;
    for (int ch = 0; ch < NUM_CHAN; ch++)
    begin
      bus_read(SLOT_CHAN_BASE + ch, 1'b0, d);
      check_eq("reset status", stat_exp(0, 1'b0, 1'b0), d);
    end
    check_eq("reset led", 32'h0, 32'(led_o));
  endtask

  task fifo_order();
    logic [7:0]  b;
    logic [7:0]  q [$];
    logic [31:0] d;
    for (int i = 0; i < 5; i++)
    begin
      rand_byte(b);
      q.push_back(b);
      push_byte(0, b);
    end
    while (q.size() > 0)
    begin
      b = q.pop_front();
      bus_read(SLOT_CHAN_BASE, 1'b1, d);
      check_eq("order data", {24'h0, b}, d);   // empty bit clear
      bus_write(SLOT_CHAN_BASE, 32'h0);        // pop
    end
    bus_read(SLOT_CHAN_BASE, 1'b0, d);
    check_eq("order drained", stat_exp(0, 1'b0, 1'b0), d);
  endtask

  task full_flags();
    logic [7:0]  b;
    logic [31:0] d;
    for (int n = 1; n <= DEPTH + 1; n++)
    begin
      rand_byte(b);
      push_byte(1, b);
      bus_read(SLOT_CHAN_BASE + 1, 1'b0, d);
      check_eq("full status", stat_exp((n > DEPTH) ? DEPTH : n, 1'b0, n > DEPTH), d);
    end
    bus_read(SLOT_CHAN_BASE + 1, 1'b0, d);
    check_eq("full flag cleared", stat_exp(DEPTH, 1'b0, 1'b0), d);
    for (int n = 0; n < DEPTH; n++)
      bus_write(SLOT_CHAN_BASE + 1, 32'h0);   // drain for later tests
  endtask

  task empty_pop();
    logic [31:0] d;
    bus_write(SLOT_CHAN_BASE + 2, 32'h0);
    bus_read(SLOT_CHAN_BASE + 2, 1'b0, d);
    check_eq("empty pop flag", stat_exp(0, 1'b1, 1'b0), d);
    bus_read(SLOT_CHAN_BASE + 2, 1'b0, d);
    check_eq("empty pop cleared", stat_exp(0, 1'b0, 1'b0), d);
  endtask

  task chan_isolation();
    logic [7:0]  b;
    logic [31:0] d;
    for (int i = 0; i < 3; i++)
    begin
      rand_byte(b);
      push_byte(3, b);
    end
    for (int ch = 0; ch < NUM_CHAN; ch++)
    begin
      bus_read(SLOT_CHAN_BASE + ch, 1'b0, d);
      check_eq("isolation count", stat_exp((ch == 3) ? 3 : 0, 1'b0, 1'b0), d);
    end
  endtask

  task led_dip_slots();
    logic [31:0] d;
    bus_write(SLOT_LED, 32'h1234_a55a);
    @(negedge msoc_clk);
    check_eq("led value", 32'h5a, 32'(led_o));
    @(posedge msoc_clk);
    dip_i <= 16'hc3e1;
    fork
      bus_read(SLOT_LED, 1'b0, d);
      begin
        @(posedge msoc_clk);
        dip_i <= 16'h1e7b;                 // moves on at the read edge
      end
    join
    check_eq("dip read", 32'h0000_c3e1, d);
    bus_read(3, 1'b0, d);
    check_eq("unmapped low slot", 32'h0, d);
    bus_read(SLOT_CHAN_BASE + NUM_CHAN, 1'b1, d);
    check_eq("unmapped high slot", 32'h0, d);
  endtask

  initial
  begin
    rstn        = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    push_i      = '0;
    push_data_i = '0;
    dip_i       = '0;
    lfsr        = 32'h2cec;
    errors      = 0;
    checks      = 0;
    repeat (8) @(posedge msoc_clk);
    rstn <= 1'b1;
    reset_state();
    fifo_order();
    full_flags();
    empty_pop();
    chan_isolation();
    led_dip_slots();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    cyc_cnt = 0;
    while (cyc_cnt < TIMEOUT_CYC)
    begin
      @(posedge msoc_clk);
      cyc_cnt++;
    end
    $display("timeout after %0d cycles, tests did not finish", cyc_cnt);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: project.f
verilog/periph_map_pkg.sv
verilog/chan_fifo_pkg.sv
verilog/slot_decoder.sv
verilog/rx_chan_fifo.sv
verilog/read_combiner.sv
verilog/periph_soc_top.sv
bench/periph_soc_chk.sv
bench/tb_periph_soc.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator; the verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_periph_soc \
  -Mdir obj_dir -o tb_periph_soc > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_periph_soc > sim.log 2>&1
grep -q "^=== PASS ===$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
